// File: rtl/console_pkg.sv
// ================================================
// Console subsystem shared types and constants
// Character, transmit and state encodings
// ================================================

package console_pkg;

   // ================================================
   // Character transport
   // ================================================

   // Which block produced a character
   typedef enum logic {
      SRC_KEYBOARD = 1'b0,
      SRC_CORE     = 1'b1
   } char_source_e;

   // One character tagged with its source
   typedef struct packed {
      char_source_e source;
      logic [7:0]   data;
   } console_char_t;

   // Character toward the console sink
   typedef struct packed {
      logic          valid;
      console_char_t ch;
   } console_tx_t;

   // ================================================
   // Control encodings
   // ================================================

   // Only LUI does anything, all else is a no-op
   typedef enum logic {
      OP_NOP = 1'b0,
      OP_LUI = 1'b1
   } opcode_e;

   // PS/2 frame receiver states
   typedef enum logic [1:0] {
      RX_IDLE   = 2'd0,
      RX_DATA   = 2'd1,
      RX_PARITY = 2'd2,
      RX_STOP   = 2'd3
   } ps2_state_e;

   // Sink buffer depth and credit counter width
   localparam int CREDITS_MAX = 4;
   localparam int CREDIT_W    = 3;

   // Instruction memory depth and matching pc width
   localparam int INSTR_WORDS = 16;
   localparam int PC_W        = $clog2(INSTR_WORDS);

   // RV32 LUI major opcode
   localparam logic [6:0] LUI_OPCODE = 7'b0110111;

   // LUI writes to x31 go out as characters
   localparam logic [4:0] CHAR_REG = 5'd31;

   // Key release prefix and fallback character
   localparam logic [7:0] BREAK_CODE   = 8'hF0;
   localparam logic [7:0] UNKNOWN_CHAR = 8'h3F;

endpackage

// File: rtl/ps2_receiver.sv
// ================================================
// PS/2 receiver
// Synchronizes the PS/2 lines and checks 11-bit frames
// ================================================
`timescale 1ns/100ps

module ps2_receiver (
   input  logic       clock_1hz,
   input  logic       KEY0,
   input  logic       ps2_clk,
   input  logic       ps2_data,
   output logic [7:0] scan_code,
   output logic       scan_valid
);

   // Two-flop synchronizers, idle level is high
   logic [1:0] clk_sync;
   logic [1:0] data_sync;
   // Previous synchronized clock for edge detection
   logic       clk_prev;
   logic       clk_fall;
   // Frame assembly
   logic [7:0] shift_reg;
   logic [2:0] bit_cnt;
   logic       parity_ok;
   console_pkg::ps2_state_e state;

   // ================================================
   // Synchronizers and falling edge detect
   // ================================================
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
         clk_prev  <= 1'b1;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk};
         data_sync <= {data_sync[0], ps2_data};
         clk_prev  <= clk_sync[1];
      end
   end

   // Device changes data on rising edge, host samples on falling
   assign clk_fall = clk_prev & ~clk_sync[1];

   // ================================================
   // Frame FSM
   // ================================================
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         state      <= console_pkg::RX_IDLE;
         bit_cnt    <= 3'd0;
         parity_ok  <= 1'b0;
         scan_valid <= 1'b0;
      end else begin
         // Pulse lasts a single cycle
         scan_valid <= 1'b0;
         if (clk_fall) begin
            case (state)
               console_pkg::RX_IDLE: begin
                  // Start bit is low
                  if (!data_sync[1]) begin
                     state   <= console_pkg::RX_DATA;
                     bit_cnt <= 3'd0;
                  end
               end
               console_pkg::RX_DATA: begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     state <= console_pkg::RX_PARITY;
                  end
               end
               console_pkg::RX_PARITY: begin
                  // Odd parity over data plus parity bit
                  parity_ok <= ^{shift_reg, data_sync[1]};
                  state     <= console_pkg::RX_STOP;
               end
               console_pkg::RX_STOP: begin
                  // Bad stop or parity drops the frame
                  scan_valid <= data_sync[1] & parity_ok;
                  state      <= console_pkg::RX_IDLE;
               end
               default: state <= console_pkg::RX_IDLE;
            endcase
         end
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clock_1hz) begin
      if (clk_fall && state == console_pkg::RX_DATA) begin
         shift_reg <= {data_sync[1], shift_reg[7:1]};
      end
   end

   assign scan_code = shift_reg;

endmodule

// File: rtl/scan_decoder.sv
// ================================================
// Scan code decoder
// Drops break sequences, maps digit make codes to ASCII
// ================================================
`timescale 1ns/100ps

module scan_decoder (
   input  logic                      clock_1hz,
   input  logic                      KEY0,
   input  logic [7:0]                scan_code,
   input  logic                      scan_valid,
   output console_pkg::console_char_t kb_char,
   output logic                      kb_valid,
   input  logic                      kb_ready
);

   logic       break_seen;
   logic [7:0] kb_data;
   logic       load;

   // Main row and keypad digits, anything else is unknown
   function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
      case (code)
         8'h45, 8'h70: scan_to_ascii = "0";
         8'h16, 8'h69: scan_to_ascii = "1";
         8'h1E, 8'h72: scan_to_ascii = "2";
         8'h26, 8'h7A: scan_to_ascii = "3";
         8'h25, 8'h6B: scan_to_ascii = "4";
         8'h2E, 8'h73: scan_to_ascii = "5";
         8'h36, 8'h74: scan_to_ascii = "6";
         8'h3D, 8'h6C: scan_to_ascii = "7";
         8'h3E, 8'h75: scan_to_ascii = "8";
         8'h46, 8'h7D: scan_to_ascii = "9";
         default:      scan_to_ascii = console_pkg::UNKNOWN_CHAR;
      endcase
   endfunction

   // Take a make code only if the holding slot is free or being freed
   assign load = scan_valid && scan_code != console_pkg::BREAK_CODE &&
                 !break_seen && (!kb_valid || kb_ready);

   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         break_seen <= 1'b0;
         kb_valid   <= 1'b0;
      end else begin
         // Code after F0 is the released key, swallow it
         if (scan_valid) begin
            break_seen <= (scan_code == console_pkg::BREAK_CODE);
         end
         if (load) begin
            kb_valid <= 1'b1;
         end else if (kb_ready) begin
            kb_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock_1hz) begin
      if (load) begin
         kb_data <= scan_to_ascii(scan_code);
      end
   end

   assign kb_char.source = console_pkg::SRC_KEYBOARD;
   assign kb_char.data   = kb_data;

endmodule

// File: rtl/lui_core.sv
// ================================================
// LUI-only core
// Two-stage fetch/execute, x31 writes become characters
// ================================================
`timescale 1ns/100ps

module lui_core (
   input  logic                      clock_1hz,
   input  logic                      KEY0,
   output console_pkg::console_char_t core_char,
   output logic                      core_valid,
   input  logic                      core_ready,
   output logic [7:0]                led_green,
   output logic [7:0]                led_red,
   output logic                      heartbeat
);

   logic [31:0] imem [console_pkg::INSTR_WORDS];
   logic [31:0] regs [32];
   logic [console_pkg::PC_W-1:0] pc;
   logic [31:0] ir;
   logic [31:0] fetch_word;
   logic [4:0]  rd;
   logic [31:0] imm_u;
   console_pkg::opcode_e op;
   logic        stall;
   logic        emit;

   // Words are stored little-endian
   initial $readmemh("dv/program.mem", imem);

   // ================================================
   // Fetch
   // ================================================
   assign fetch_word = {imem[pc][7:0], imem[pc][15:8],
                        imem[pc][23:16], imem[pc][31:24]};

   // Whole pipeline freezes while a character waits
   assign stall = core_valid & ~core_ready;

   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         pc <= '0;
         ir <= 32'h0;
      end else if (!stall) begin
         // pc wraps naturally at INSTR_WORDS
         pc <= pc + 1'b1;
         ir <= fetch_word;
      end
   end

   // ================================================
   // Execute
   // ================================================
   assign rd    = ir[11:7];
   assign imm_u = {ir[31:12], 12'h000};

   always_comb begin
      if (ir[6:0] == console_pkg::LUI_OPCODE) begin
         op = console_pkg::OP_LUI;
      end else begin
         op = console_pkg::OP_NOP;
      end
   end

   assign emit = (op == console_pkg::OP_LUI) && (rd == console_pkg::CHAR_REG);

   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= 32'h0;
         end
      end else if (!stall && op == console_pkg::OP_LUI && rd != 5'd0) begin
         // x0 is hardwired to zero
         regs[rd] <= imm_u;
      end
   end

   // Character flag and heartbeat
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         core_valid <= 1'b0;
         heartbeat  <= 1'b0;
      end else begin
         heartbeat <= ~heartbeat;
         if (!stall) begin
            core_valid <= emit;
         end
      end
   end

   // x31 holds steady during a stall, so it doubles as character data
   assign core_char.source = console_pkg::SRC_CORE;
   assign core_char.data   = regs[console_pkg::CHAR_REG][19:12];

   assign led_green = ir[7:0];
   assign led_red   = regs[console_pkg::CHAR_REG][19:12];

endmodule

// File: rtl/console_arbiter.sv
// ================================================
// Console arbiter
// Keyboard-first merge with credit flow to the sink
// ================================================
`timescale 1ns/100ps

module console_arbiter (
   input  logic                      clock_1hz,
   input  logic                      KEY0,
   input  console_pkg::console_char_t kb_char,
   input  logic                      kb_valid,
   output logic                      kb_ready,
   input  console_pkg::console_char_t core_char,
   input  logic                      core_valid,
   output logic                      core_ready,
   output console_pkg::console_tx_t  tx,
   input  logic                      credit_return
);

   // Free slots in the sink buffer
   logic [console_pkg::CREDIT_W-1:0] credits;
   logic                             has_credit;
   logic                             send;
   console_pkg::console_char_t       chosen;
   // Output register
   logic                             tx_valid;
   console_pkg::console_char_t       tx_ch;

   // ================================================
   // Source selection
   // ================================================
   assign has_credit = (credits != '0);

   // Keyboard wins a tie, no credit means nobody is accepted
   assign kb_ready   = has_credit & kb_valid;
   assign core_ready = has_credit & core_valid & ~kb_valid;
   assign send       = kb_ready | core_ready;

   always_comb begin
      if (kb_valid) begin
         chosen = kb_char;
      end else begin
         chosen = core_char;
      end
   end

   // ================================================
   // Credit counter
   // ================================================
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         credits <= console_pkg::CREDIT_W'(console_pkg::CREDITS_MAX);
      end else begin
         case ({send, credit_return})
            // Send only
            2'b10: credits <= credits - 1'b1;
            // Return only
            2'b01: credits <= credits + 1'b1;
            // Both or neither leave the count alone
            default: credits <= credits;
         endcase
      end
   end

   // ================================================
   // Output register
   // ================================================
   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         tx_valid <= 1'b0;
      end else begin
         // One cycle per accepted character
         tx_valid <= send;
      end
   end

   always_ff @(posedge clock_1hz) begin
      if (send) begin
         tx_ch <= chosen;
      end
   end

   assign tx.valid = tx_valid;
   assign tx.ch    = tx_ch;

endmodule

// File: rtl/keyboard_console.sv
// ================================================
// Keyboard console top level
// PS/2 path and LUI core merged onto one console port
// ================================================
`timescale 1ns/100ps

module keyboard_console (
   input  logic                     clock_1hz,
   input  logic                     KEY0,
   input  logic                     ps2_clk,
   input  logic                     ps2_data,
   output console_pkg::console_tx_t tx,
   input  logic                     credit_return,
   output logic [7:0]               led_green,
   output logic [7:0]               led_red,
   output logic                     heartbeat
);

   // Receiver to decoder
   logic [7:0] scan_code;
   logic       scan_valid;
   // Keyboard character handshake
   console_pkg::console_char_t kb_char;
   logic                       kb_valid;
   logic                       kb_ready;
   // Core character handshake
   console_pkg::console_char_t core_char;
   logic                       core_valid;
   logic                       core_ready;

   ps2_receiver i_ps2_receiver (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .ps2_clk   (ps2_clk),
      .ps2_data  (ps2_data),
      .scan_code (scan_code),
      .scan_valid(scan_valid)
   );

   scan_decoder i_scan_decoder (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .scan_code (scan_code),
      .scan_valid(scan_valid),
      .kb_char   (kb_char),
      .kb_valid  (kb_valid),
      .kb_ready  (kb_ready)
   );

   lui_core i_lui_core (
      .clock_1hz (clock_1hz),
      .KEY0      (KEY0),
      .core_char (core_char),
      .core_valid(core_valid),
      .core_ready(core_ready),
      .led_green (led_green),
      .led_red   (led_red),
      .heartbeat (heartbeat)
   );

   console_arbiter i_console_arbiter (
      .clock_1hz    (clock_1hz),
      .KEY0         (KEY0),
      .kb_char      (kb_char),
      .kb_valid     (kb_valid),
      .kb_ready     (kb_ready),
      .core_char    (core_char),
      .core_valid   (core_valid),
      .core_ready   (core_ready),
      .tx           (tx),
      .credit_return(credit_return)
   );

endmodule

// File: dv/keyboard_console_properties.sv
// ================================================
// Keyboard console assertions
// Credit, reset, heartbeat and core stall checks on the top level
// ================================================
`timescale 1ns/100ps

module keyboard_console_properties (
   input logic                       clock_1hz,
   input logic                       KEY0,
   input console_pkg::console_tx_t   tx,
   input logic                       credit_return,
   input logic                       kb_valid,
   input logic                       kb_ready,
   input logic                       core_ready,
   input logic                       core_valid,
   input console_pkg::console_char_t core_char,
   input logic [7:0]                 led_green,
   input logic [7:0]                 led_red,
   input logic                       heartbeat
);

   // Characters out at the sink and not yet returned
   int         outstanding;
   // Data of the last core character seen on tx
   logic [7:0] last_core;
   logic       core_sent;
   // Sticky flags, one per assertion
   logic reset_bad      = 1'b0;
   logic release_bad    = 1'b0;
   logic credit_bad     = 1'b0;
   logic pulse_bad      = 1'b0;
   logic stall_bad      = 1'b0;
   logic led_bad        = 1'b0;
   logic beat_reset_bad = 1'b0;
   logic beat_bad       = 1'b0;
   logic any_failed;

   assign any_failed = reset_bad | release_bad | credit_bad | pulse_bad |
                       stall_bad | led_bad | beat_reset_bad | beat_bad;

   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(tx.valid) - int'(credit_return);
      end
   end

   always_ff @(posedge clock_1hz or negedge KEY0) begin
      if (!KEY0) begin
         core_sent <= 1'b0;
         last_core <= 8'h00;
      end else if (tx.valid && tx.ch.source == console_pkg::SRC_CORE) begin
         core_sent <= 1'b1;
         last_core <= tx.ch.data;
      end
   end

   // ================================================
   // Reset
   // ================================================
   reset_quiet: assert property (@(posedge clock_1hz) !KEY0 |-> !tx.valid)
      else begin
         reset_bad = 1'b1;
         $error("tx.valid high during reset");
      end

   release_quiet: assert property (@(posedge clock_1hz) $rose(KEY0) |=> !tx.valid)
      else begin
         release_bad = 1'b1;
         $error("tx.valid high in the cycle after reset release");
      end

   // ================================================
   // Credits and output pulses
   // ================================================
   credit_limit: assert property (@(posedge clock_1hz) disable iff (!KEY0)
      outstanding <= console_pkg::CREDITS_MAX)
      else begin
         credit_bad = 1'b1;
         $error("More characters outstanding than the sink can buffer");
      end

   // Each tx pulse needs its own source handshake one cycle earlier
   one_pulse: assert property (@(posedge clock_1hz) disable iff (!KEY0)
      tx.valid |-> $past((kb_valid && kb_ready) || (core_valid && core_ready)))
      else begin
         pulse_bad = 1'b1;
         $error("tx.valid without a matching acceptance");
      end

   // ================================================
   // Core stall
   // ================================================
   core_hold: assert property (@(posedge clock_1hz) disable iff (!KEY0)
      core_valid && !core_ready |=>
         core_valid && $stable(core_char) && $stable(led_green))
      else begin
         stall_bad = 1'b1;
         $error("Core moved on while its character waited");
      end

   // Nothing from the core waiting or on tx, so led_red shows the last one sent
   led_follow: assert property (@(posedge clock_1hz) disable iff (!KEY0)
      core_sent && !core_valid && !(tx.valid && tx.ch.source == console_pkg::SRC_CORE)
         |-> led_red == last_core)
      else begin
         led_bad = 1'b1;
         $error("led_red differs from the last core character");
      end

   // ================================================
   // Heartbeat
   // ================================================
   beat_reset: assert property (@(posedge clock_1hz) !KEY0 |-> !heartbeat)
      else begin
         beat_reset_bad = 1'b1;
         $error("heartbeat high during reset");
      end

   // Toggles on every clock once out of reset
   beat_toggle: assert property (@(posedge clock_1hz) disable iff (!KEY0)
      $past(KEY0) |-> heartbeat != $past(heartbeat))
      else begin
         beat_bad = 1'b1;
         $error("heartbeat missed a toggle");
      end

endmodule

bind keyboard_console keyboard_console_properties i_properties (
   .clock_1hz    (clock_1hz),
   .KEY0         (KEY0),
   .tx           (tx),
   .credit_return(credit_return),
   .kb_valid     (kb_valid),
   .kb_ready     (kb_ready),
   .core_ready   (core_ready),
   .core_valid   (core_valid),
   .core_char    (core_char),
   .led_green    (led_green),
   .led_red      (led_red),
   .heartbeat    (heartbeat)
);

// File: dv/tb_keyboard_console.sv
// ================================================
// Keyboard console testbench
// PS/2 frames, credit sink and character scoreboard
// ================================================
`timescale 1ns/100ps

module tb_keyboard_console;

   // Four system cycles per PS/2 half period, two idle half periods per frame
   localparam int HALF_CYCLES    = 4;
   localparam int FRAME_CYCLES   = 11 * 2 * HALF_CYCLES + 2 * HALF_CYCLES;
   localparam int NUM_FRAMES     = 11;
   localparam int TIMEOUT_CYCLES =
      2 * (NUM_FRAMES * FRAME_CYCLES + console_pkg::INSTR_WORDS);

   // DUT ports
   logic                     clock_1hz;
   logic                     KEY0;
   logic                     ps2_clk;
   logic                     ps2_data;
   logic                     credit_return;
   console_pkg::console_tx_t tx;
   logic [7:0]               led_green;
   logic [7:0]               led_red;
   logic                     heartbeat;

   // Expected characters, kept per source
   logic [7:0]  kb_exp[$];
   string       kb_test[$];
   logic [7:0]  core_exp[$];
   logic [31:0] program_words [console_pkg::INSTR_WORDS];
   int          core_seen = 0;
   // Sink model
   int          sent_count = 0;
   int          returned_count = 0;
   int          return_delay = 0;
   logic        credits_on;
   int          cycle_count = 0;

   keyboard_console i_dut (
      .clock_1hz    (clock_1hz),
      .KEY0         (KEY0),
      .ps2_clk      (ps2_clk),
      .ps2_data     (ps2_data),
      .tx           (tx),
      .credit_return(credit_return),
      .led_green    (led_green),
      .led_red      (led_red),
      .heartbeat    (heartbeat)
   );

   // 100 ns clock period
   initial begin
      clock_1hz = 1'b0;
      forever #50 clock_1hz = ~clock_1hz;
   end

   // ================================================
   // Helpers
   // ================================================
   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // Instruction words sit in memory little-endian
   function automatic logic [31:0] swap_bytes(input logic [31:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   // One PS/2 half period on both lines
   task automatic hold_ps2(input logic clk_level, input logic data_level);
      repeat (HALF_CYCLES) begin
         @(posedge clock_1hz);
         ps2_clk  <= clk_level;
         ps2_data <= data_level;
      end
   endtask

   // Start, 8 data bits LSB first, odd parity, stop
   task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                             input logic bad_stop);
      logic [10:0] bits;
      int          i;
      bits = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0};
      for (i = 0; i < 11; i++) begin
         // Data settles while the clock is high, host samples on the fall
         hold_ps2(1'b1, bits[i]);
         hold_ps2(1'b0, bits[i]);
      end
      hold_ps2(1'b1, 1'b1);
      hold_ps2(1'b1, 1'b1);
   endtask

   // Good frame that should come out as a keyboard character
   task automatic push_key(input logic [7:0] code, input logic [7:0] ascii,
                           input string name);
      kb_exp.push_back(ascii);
      kb_test.push_back(name);
      send_frame(code, 1'b0, 1'b0);
   endtask

   task automatic check_keyboard(input logic [7:0] actual);
      logic [7:0] expected;
      string      name;
      assert (kb_exp.size() != 0) else
         stop_with_failure($sformatf("Keyboard character %h arrived, none expected",
                                     actual));
      expected = kb_exp.pop_front();
      name     = kb_test.pop_front();
      assert (actual == expected) else
         stop_with_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name, expected, actual));
   endtask

   // Core characters repeat as the pc wraps
   task automatic check_core(input logic [7:0] actual);
      logic [7:0] expected;
      expected = core_exp[core_seen % core_exp.size()];
      core_seen++;
      assert (actual == expected) else
         stop_with_failure($sformatf("CHECK FAILED core_program: expected %h, actual %h",
                                     expected, actual));
   endtask

   // ================================================
   // Monitor and sink
   // ================================================
   // tx is a register, stable at the falling edge
   always @(negedge clock_1hz) begin
      if (KEY0 && tx.valid) begin
         sent_count++;
         if (tx.ch.source == console_pkg::SRC_KEYBOARD) begin
            check_keyboard(tx.ch.data);
         end else begin
            check_core(tx.ch.data);
         end
      end
   end

   // Credits go back one at a time after a random wait
   always @(posedge clock_1hz) begin
      if (credits_on && sent_count > returned_count && return_delay == 0) begin
         credit_return <= 1'b1;
         returned_count++;
         return_delay = $urandom_range(7, 0);
      end else begin
         credit_return <= 1'b0;
         if (return_delay > 0) begin
            return_delay--;
         end
      end
   end

   // Run limit and bound assertion status
   always @(posedge clock_1hz) begin
      cycle_count++;
      assert (cycle_count < TIMEOUT_CYCLES) else
         stop_with_failure($sformatf("Timeout after %0d cycles, characters still missing",
                                     cycle_count));
      assert (!i_dut.i_properties.any_failed) else
         stop_with_failure("A bound assertion on the console top level failed");
   end

   // ================================================
   // Stimulus
   // ================================================
   initial begin
      logic [31:0] instr;
      int          i;
      void'($urandom(32'h8c53));
      KEY0          = 1'b0;
      ps2_clk       = 1'b1;
      ps2_data      = 1'b1;
      credit_return = 1'b0;
      credits_on    = 1'b0;

      // x31 LUI immediates in program order
      $readmemh("dv/program.mem", program_words);
      for (i = 0; i < console_pkg::INSTR_WORDS; i++) begin
         instr = swap_bytes(program_words[i]);
         if (instr[6:0] == 7'b0110111 && instr[11:7] == console_pkg::CHAR_REG) begin
            core_exp.push_back(instr[19:12]);
         end
      end
      assert (core_exp.size() != 0) else
         stop_with_failure("Program holds no character writes to x31");

      repeat (3) @(posedge clock_1hz);
      KEY0 <= 1'b1;

      // Sink withholds credits, the core uses them all
      while (sent_count < console_pkg::CREDITS_MAX) begin
         @(posedge clock_1hz);
      end
      // First key waits, the second one is dropped
      push_key(8'h1E, "2", "kb_discard");
      send_frame(8'h26, 1'b0, 1'b0);
      repeat (8) @(posedge clock_1hz);
      assert (sent_count == console_pkg::CREDITS_MAX) else
         stop_with_failure($sformatf("CHECK FAILED credit_stall: expected %0d, actual %0d",
                                     console_pkg::CREDITS_MAX, sent_count));
      credits_on <= 1'b1;

      // Main row, keypad and unmapped codes
      push_key(8'h16, "1", "kb_digits");
      push_key(8'h70, "0", "kb_digits");
      push_key(8'h1C, "?", "kb_digits");
      // Release of key 1, then a fresh press
      send_frame(8'hF0, 1'b0, 1'b0);
      send_frame(8'h16, 1'b0, 1'b0);
      push_key(8'h16, "1", "break_codes");
      // Even parity, then low stop bit
      send_frame(8'h25, 1'b1, 1'b0);
      send_frame(8'h2E, 1'b0, 1'b1);
      push_key(8'h45, "0", "bad_frames");

      // Drain keys and see the program loop at least twice
      while (kb_exp.size() != 0 || core_seen < 2 * core_exp.size()) begin
         @(posedge clock_1hz);
      end
      repeat (4) @(posedge clock_1hz);
      if (kb_exp.size() == 0 && !i_dut.i_properties.any_failed) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal(1);
      end
   end

endmodule

// File: dv/program.mem
// One 32-bit instruction per line, bytes stored little-endian
// The core swaps each word back before decoding
B78F0400 // lui x31, 'H'
B7523412 // lui x5, 0x12345
13000000 // nop
B79F0600 // lui x31, 'i'
B71F0200 // lui x31, '!'
B3003100 // add x1, x2, x3
37A00500 // lui x0, 'Z'
B7FF0400 // lui x31, 'O'
B7BF0400 // lui x31, 'K'
37AF0700 // lui x30, 'z'
13000000 // nop
13000000 // nop
13000000 // nop
13000000 // nop
13000000 // nop
13000000 // nop

// File: filelist.f
rtl/console_pkg.sv
rtl/ps2_receiver.sv
rtl/scan_decoder.sv
rtl/lui_core.sv
rtl/console_arbiter.sv
rtl/keyboard_console.sv
dv/keyboard_console_properties.sv
dv/tb_keyboard_console.sv

// File: Makefile
# Verilator build and run for the keyboard console testbench

TOP := tb_keyboard_console

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

# Pass or fail comes from the simulation log
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
